//--- hdl/demap_macros.svh
// Width macros for demapper input samples, raw soft metrics and output LLRs
`ifndef DEMAP_MACROS_SVH
`define DEMAP_MACROS_SVH

// Input sample width, per re/im component
`define DEMAP_IDAT_W 8

// Raw metric width
// One guard bit so re+im and im-re never wrap
`define DEMAP_MET_W (`DEMAP_IDAT_W + 1)

// Output soft value width after symmetric clipping
`define DEMAP_LLR_W 6

// Worked ranges at the default widths
//   input      -128 .. +127
//   raw metric -256 .. +255
//   LLR         -31 ..  +31 (symmetric, -32 never produced)

`endif // DEMAP_MACROS_SVH

//--- hdl/dvb_frame_pkg.sv
// Frame level types: modulation code and pi/2 symbol phase
`default_nettype none

`include "demap_macros.svh"

package dvb_frame_pkg;

  // Modulation code, latched once per frame on sop
  typedef enum logic {
    MOD_PI2_BPSK = 1'b0, // one LLR per symbol
    MOD_QPSK     = 1'b1  // two LLRs per symbol
  } mod_t;

  // Parity of a symbol inside the frame
  // pi/2 BPSK rotates by 90 degrees on every odd symbol
  typedef enum logic {
    PHASE_EVEN = 1'b0, // first symbol after sop
    PHASE_ODD  = 1'b1
  } sym_phase_t;

endpackage : dvb_frame_pkg

`default_nettype wire

//--- hdl/dvb_llr_pkg.sv
// Soft value types: input sample, raw metric, saturated LLR and clip limit
`default_nettype none

`include "demap_macros.svh"

package dvb_llr_pkg;

  // Signed input component, re or im
  typedef logic signed [`DEMAP_IDAT_W-1:0] sample_t;

  // Raw metric before clipping, one bit wider than the sample
  typedef logic signed [`DEMAP_MET_W-1:0] metric_t;

  // Clipped soft value handed to the decoder
  typedef logic signed [`DEMAP_LLR_W-1:0] llr_t;

  // Largest LLR magnitude
  // Negative side stops at -LLR_MAX, so the range is symmetric
  localparam int LLR_MAX = 2**(`DEMAP_LLR_W-1) - 1;

endpackage : dvb_llr_pkg

`default_nettype wire

//--- hdl/demap_mode_decode.sv
// Decode stage: per-frame modulation latch and pi/2 symbol parity tracking
`timescale 1ns/10ps
`default_nettype none

module demap_mode_decode (
  input  logic                     iclk,
  input  logic                     rst,
  input  logic                     iclkena,
  input  logic                     isop,
  input  logic                     ival,
  input  logic                     ieop,
  input  dvb_frame_pkg::mod_t      imod,
  input  dvb_llr_pkg::sample_t     idat_re,
  input  dvb_llr_pkg::sample_t     idat_im,
  output logic                     d_sop,
  output logic                     d_val,
  output logic                     d_eop,
  output dvb_frame_pkg::mod_t      d_mod,
  output dvb_frame_pkg::sym_phase_t d_phase,
  output dvb_llr_pkg::sample_t     d_re,
  output dvb_llr_pkg::sample_t     d_im
);

  import dvb_frame_pkg::*;

  mod_t       frame_mod; // modulation of the current frame
  sym_phase_t phase_ff;  // parity of the last accepted symbol
  logic       sop_seen;  // any sop since reset
  logic       accept;
  mod_t       cur_mod;
  sym_phase_t cur_phase;

  assign accept  = iclkena & ival; // gaps in ival or a stall don't count
  assign cur_mod = isop ? imod : frame_mod; // sop symbol already uses new mode

  // Even on sop, else flip the stored parity
  assign cur_phase = isop ? PHASE_EVEN :
                     ((phase_ff == PHASE_EVEN) ? PHASE_ODD : PHASE_EVEN);

  always_ff @(posedge iclk) begin
    if (rst) begin
      d_val     <= 1'b0;
      d_sop     <= 1'b0;
      d_eop     <= 1'b0;
      frame_mod <= MOD_PI2_BPSK;
      phase_ff  <= PHASE_ODD; // next symbol counts as even
      sop_seen  <= 1'b0;
    end else if (iclkena) begin // low enable freezes the stage
      d_val <= ival;
      d_sop <= isop & ival;
      d_eop <= ieop & ival;
      if (ival) begin
        phase_ff <= cur_phase;
        if (isop) begin
          frame_mod <= imod; // held until the next sop
          sop_seen  <= 1'b1;
        end
      end
    end
  end

  // Symbol payload, no reset
  always_ff @(posedge iclk) begin
    if (accept) begin
      d_mod   <= cur_mod;
      d_phase <= cur_phase;
      d_re    <= idat_re;
      d_im    <= idat_im;
    end
  end

  // Parity and mode are undefined until a frame has started
  a_sop_first : assert property (@(posedge iclk) disable iff (rst)
    accept |-> (isop || sop_seen))
    else $error("symbol accepted before the first sop after reset");

endmodule : demap_mode_decode

`default_nettype wire

//--- hdl/demap_metric_calc.sv
// Metric stage: raw soft metrics for pi/2 BPSK and QPSK symbols
`timescale 1ns/10ps
`default_nettype none

module demap_metric_calc (
  input  logic                      iclk,
  input  logic                      rst,
  input  logic                      iclkena,
  input  logic                      d_sop,
  input  logic                      d_val,
  input  logic                      d_eop,
  input  dvb_frame_pkg::mod_t       d_mod,
  input  dvb_frame_pkg::sym_phase_t d_phase,
  input  dvb_llr_pkg::sample_t      d_re,
  input  dvb_llr_pkg::sample_t      d_im,
  output logic                      m_sop,
  output logic                      m_val,
  output logic                      m_eop,
  output dvb_frame_pkg::mod_t       m_mod,
  output dvb_llr_pkg::metric_t      m_met0,
  output dvb_llr_pkg::metric_t      m_met1
);

  import dvb_frame_pkg::*;
  import dvb_llr_pkg::*;

  metric_t re_x; // sign-extended components
  metric_t im_x;
  metric_t bpsk_met;
  metric_t met0;
  metric_t met1;

  assign re_x = metric_t'(d_re);
  assign im_x = metric_t'(d_im);

  // pi/2 rotation undone by parity
  // Guard bit keeps -256..+255 exact, clipping happens later
  assign bpsk_met = (d_phase == PHASE_EVEN) ? (re_x + im_x) : (im_x - re_x);

  always_comb begin
    if (d_mod == MOD_QPSK) begin
      met0 = re_x; // bit 0 from I
      met1 = im_x; // bit 1 from Q
    end else begin
      met0 = bpsk_met;
      met1 = '0; // unused lane
    end
  end

  always_ff @(posedge iclk) begin
    if (rst) begin
      m_val <= 1'b0;
      m_sop <= 1'b0;
      m_eop <= 1'b0;
    end else if (iclkena) begin
      m_val <= d_val;
      m_sop <= d_sop;
      m_eop <= d_eop;
    end
  end

  // Metrics only move with a valid item
  always_ff @(posedge iclk) begin
    if (iclkena && d_val) begin
      m_mod  <= d_mod;
      m_met0 <= met0;
      m_met1 <= met1;
    end
  end

endmodule : demap_metric_calc

`default_nettype wire

//--- hdl/demap_llr_sat.sv
// Result stage with symmetric LLR clipping and valid lane count
`timescale 1ns/10ps
`default_nettype none

module demap_llr_sat (
  input  logic                 iclk,
  input  logic                 rst,
  input  logic                 iclkena,
  input  logic                 m_sop,
  input  logic                 m_val,
  input  logic                 m_eop,
  input  dvb_frame_pkg::mod_t  m_mod,
  input  dvb_llr_pkg::metric_t m_met0,
  input  dvb_llr_pkg::metric_t m_met1,
  output logic                 osop,
  output logic                 oval,
  output logic                 oeop,
  output logic [1:0]           onum,
  output dvb_llr_pkg::llr_t    ollr0,
  output dvb_llr_pkg::llr_t    ollr1
);

  import dvb_frame_pkg::*;
  import dvb_llr_pkg::*;

  logic [1:0] lanes;
  llr_t       llr0;
  llr_t       llr1;
  logic [1:0] num_prev; // lane count of the previous output

  // Clip to +-LLR_MAX so -LLR_MAX-1 never leaves the stage
  function automatic llr_t sat_llr(input metric_t met);
    if (met > metric_t'(LLR_MAX))
      return llr_t'(LLR_MAX);
    else if (met < metric_t'(-LLR_MAX))
      return llr_t'(-LLR_MAX);
    else
      return llr_t'(met); // In range so the upper bits are only sign
  endfunction

  assign lanes = (m_mod == MOD_QPSK) ? 2'd2 : 2'd1;
  assign llr0  = sat_llr(m_met0);
  assign llr1  = (m_mod == MOD_QPSK) ? sat_llr(m_met1) : '0; // BPSK lane 1 idle

  always_ff @(posedge iclk) begin
    if (rst) begin
      oval <= 1'b0;
      osop <= 1'b0;
      oeop <= 1'b0;
      onum <= 2'd0;
    end else if (iclkena) begin
      oval <= m_val;
      osop <= m_sop;
      oeop <= m_eop;
      onum <= m_val ? lanes : 2'd0; // zero between items
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && m_val) begin
      ollr0 <= llr0;
      ollr1 <= llr1;
    end
  end

  // Remembered when the next enabled edge moves past an output
  always_ff @(posedge iclk) begin
    if (iclkena && oval)
      num_prev <= onum;
  end

  // 1 or 2 lanes, fixed from sop to eop by the mode latched in decode
  a_onum_range : assert property (@(posedge iclk) disable iff (rst)
    oval |-> (onum == 2'd1 || onum == 2'd2) && (osop || onum == num_prev))
    else $error("oval with lane count %0d after an output with %0d", onum, num_prev);

endmodule : demap_llr_sat

`default_nettype wire

//--- hdl/dvb_soft_demapper.sv
// Top level soft demapper: decode, metric and saturation stages in a row
`timescale 1ns/10ps
`default_nettype none

module dvb_soft_demapper (
  input  logic                 iclk,
  input  logic                 rst,
  input  logic                 iclkena,
  input  logic                 isop,
  input  logic                 ival,
  input  logic                 ieop,
  input  dvb_frame_pkg::mod_t  imod,
  input  dvb_llr_pkg::sample_t idat_re,
  input  dvb_llr_pkg::sample_t idat_im,
  output logic                 osop,
  output logic                 oval,
  output logic                 oeop,
  output logic [1:0]           onum,
  output dvb_llr_pkg::llr_t    ollr0,
  output dvb_llr_pkg::llr_t    ollr1
);

  import dvb_frame_pkg::*;
  import dvb_llr_pkg::*;

  // Decode to metric
  logic       d_sop;
  logic       d_val;
  logic       d_eop;
  mod_t       d_mod;
  sym_phase_t d_phase;
  sample_t    d_re;
  sample_t    d_im;

  // Metric to saturation
  logic       m_sop;
  logic       m_val;
  logic       m_eop;
  mod_t       m_mod;
  metric_t    m_met0;
  metric_t    m_met1;

  demap_mode_decode u_decode (
    .iclk    (iclk),    .rst   (rst),   .iclkena (iclkena),
    .isop    (isop),    .ival  (ival),  .ieop    (ieop),
    .imod    (imod),    .idat_re (idat_re), .idat_im (idat_im),
    .d_sop   (d_sop),   .d_val (d_val), .d_eop   (d_eop),
    .d_mod   (d_mod),   .d_phase (d_phase),
    .d_re    (d_re),    .d_im  (d_im)
  );

  demap_metric_calc u_metric (
    .iclk    (iclk),    .rst   (rst),   .iclkena (iclkena),
    .d_sop   (d_sop),   .d_val (d_val), .d_eop   (d_eop),
    .d_mod   (d_mod),   .d_phase (d_phase),
    .d_re    (d_re),    .d_im  (d_im),
    .m_sop   (m_sop),   .m_val (m_val), .m_eop   (m_eop),
    .m_mod   (m_mod),   .m_met0 (m_met0), .m_met1 (m_met1)
  );

  demap_llr_sat u_sat (
    .iclk    (iclk),    .rst   (rst),   .iclkena (iclkena),
    .m_sop   (m_sop),   .m_val (m_val), .m_eop   (m_eop),
    .m_mod   (m_mod),   .m_met0 (m_met0), .m_met1 (m_met1),
    .osop    (osop),    .oval  (oval),  .oeop    (oeop),
    .onum    (onum),    .ollr0 (ollr0), .ollr1   (ollr1)
  );

endmodule : dvb_soft_demapper

`default_nettype wire

//--- bench/tb_clkgen.sv
// Testbench clock and reset source, 8 ns period and two-cycle reset
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic iclk,
  output logic rst
);

  initial begin
    iclk = 1'b0;
    forever #(PERIOD_NS / 2) iclk = ~iclk;
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge iclk); // two full cycles in reset
    rst <= 1'b0;
  end

endmodule : tb_clkgen

`default_nettype wire

//--- bench/tb_dvb_soft_demapper.sv
// Soft demapper testbench: stimulus table, reference model, typed checks and report
`timescale 1ns/10ps
`default_nettype none

module tb_dvb_soft_demapper;

  import dvb_frame_pkg::*;
  import dvb_llr_pkg::*;

  typedef struct packed {
    int         test;
    logic       sop, val, eop, ena;
    mod_t       mod;
    sample_t    re, im;
    llr_t       l0, l1;   // expected lanes
    logic [1:0] num;
    int         acc_edge; // enabled edge that took the symbol
  } row_t;

  logic       iclk, rst, iclkena, isop, ival, ieop;
  mod_t       imod;
  sample_t    idat_re, idat_im;
  logic       osop, oval, oeop;
  logic [1:0] onum;
  llr_t       ollr0, ollr1;
  logic [1:0] prev_flags = 2'b00; // oval/osop seen after the previous edge
  row_t       rows[$];
  row_t       exp_q[$];           // outputs still due, oldest first
  row_t       idle;
  int         seed = 32'h29f9_7254;
  int         ena_cnt = 0;
  int         errors = 0;
  int         test_out;
  int         total_out = 0;
  bit         timed_out = 1'b0;
  string      names[7] = '{"reset", "bpsk_parity", "gaps_stall", "qpsk_lanes",
                           "saturation", "mode_latch", "random"};

  tb_clkgen u_clkgen (.iclk(iclk), .rst(rst));

  dvb_soft_demapper DUT (.*);

  task automatic check_llr(input string name, input llr_t got, input llr_t want);
    if (got !== want) begin
      errors++;
      $display("[FAIL] %0t ns %s got %0d expected %0d", $time, name, got, want);
    end
  endtask

  task automatic check_num(input string name, input logic [1:0] got, input logic [1:0] want);
    if (got !== want) begin
      errors++;
      $display("[FAIL] %0t ns %s got %0d expected %0d", $time, name, got, want);
    end
  endtask

  task automatic check_flags(input string name, input logic [1:0] got, input logic [1:0] want);
    if (got !== want) begin
      errors++;
      $display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, want);
    end
  endtask

  // Symmetric clip to +-31
  function automatic int clip_llr(input int v);
    return (v > LLR_MAX) ? LLR_MAX : ((v < -LLR_MAX) ? -LLR_MAX : v);
  endfunction

  // Lane 0 reference: QPSK takes re, pi/2 BPSK derotates by parity
  function automatic int ref_lane0(input mod_t m, input bit odd, input int re, input int im);
    if (m == MOD_QPSK)
      return clip_llr(re);
    return clip_llr(odd ? im - re : re + im);
  endfunction

  task automatic add_row(input int t, input bit sop, input bit val, input bit eop,
                         input bit ena, input mod_t m, input int re, input int im,
                         input int x0, input int x1, input int n);
    rows.push_back(row_t'{t, sop, val, eop, ena, m, sample_t'(re), sample_t'(im),
                          llr_t'(x0), llr_t'(x1), 2'(n), 0});
  endtask

  task automatic load_directed();
    add_row(1, 1, 1, 0, 1, MOD_PI2_BPSK, 10, 5, 15, 0, 1);   // Even, re+im
    add_row(1, 0, 1, 0, 1, MOD_PI2_BPSK, 10, 5, -5, 0, 1);   // Odd, im-re
    add_row(1, 0, 1, 0, 1, MOD_PI2_BPSK, 3, -7, -4, 0, 1);
    add_row(1, 1, 1, 0, 1, MOD_PI2_BPSK, 4, 9, 13, 0, 1);    // Odd was due, sop forces even
    add_row(1, 0, 1, 1, 1, MOD_PI2_BPSK, 4, 9, 5, 0, 1);
    add_row(2, 1, 1, 0, 1, MOD_PI2_BPSK, 6, 2, 8, 0, 1);
    add_row(2, 0, 0, 0, 1, MOD_PI2_BPSK, 100, -100, 0, 0, 0); // Gap in ival
    add_row(2, 0, 1, 0, 1, MOD_PI2_BPSK, 6, 2, -4, 0, 1);
    add_row(2, 0, 1, 0, 0, MOD_PI2_BPSK, 50, 50, 0, 0, 0);    // Stall, not taken
    add_row(2, 0, 1, 1, 1, MOD_PI2_BPSK, 6, 2, 8, 0, 1);
    add_row(3, 1, 1, 0, 1, MOD_QPSK, 12, -20, 12, -20, 2);
    add_row(3, 0, 1, 0, 1, MOD_QPSK, -128, 127, -31, 31, 2);
    add_row(3, 0, 1, 1, 1, MOD_QPSK, 100, -100, 31, -31, 2);
    add_row(3, 1, 1, 1, 1, MOD_PI2_BPSK, 1, 2, 3, 0, 1);     // One-symbol BPSK frame
    add_row(4, 1, 1, 0, 1, MOD_PI2_BPSK, 127, 127, 31, 0, 1); // 254
    add_row(4, 0, 1, 0, 1, MOD_PI2_BPSK, 127, -128, -31, 0, 1);
    add_row(4, 0, 1, 0, 1, MOD_PI2_BPSK, -128, -128, -31, 0, 1); // -256
    add_row(4, 0, 1, 0, 1, MOD_PI2_BPSK, -100, -70, 30, 0, 1); // In range
    add_row(4, 0, 1, 1, 1, MOD_PI2_BPSK, -16, -16, -31, 0, 1); // -32 clips
    add_row(5, 1, 1, 0, 1, MOD_QPSK, 5, 6, 5, 6, 2);
    add_row(5, 0, 1, 1, 1, MOD_PI2_BPSK, 7, -8, 7, -8, 2);   // Mode change ignored
    add_row(5, 1, 1, 0, 1, MOD_PI2_BPSK, 5, 6, 11, 0, 1);
    add_row(5, 0, 1, 1, 1, MOD_QPSK, 5, 6, 1, 0, 1);
  endtask

  // Random frames with gaps and stalls
  task automatic fill_random();
    int   len, re, im, x0, x1;
    bit   val, ena, odd;
    mod_t fm, m;
    for (int f = 0; f < 4; f++) begin
      len = 6 + ($random(seed) & 7);
      fm  = mod_t'($random(seed) & 1);
      odd = 1'b0; // sop symbol is even
      for (int k = 0; k < len; k++) begin
        val = (k == 0) || (k == len - 1) || (($random(seed) & 3) != 0);
        ena = (k == 0) || (k == len - 1) || (($random(seed) & 3) != 0);
        re  = int'(sample_t'($random(seed)));
        im  = int'(sample_t'($random(seed)));
        m   = (k == 0) ? fm : mod_t'($random(seed) & 1);
        x0  = ref_lane0(fm, odd, re, im);
        x1  = (fm == MOD_QPSK) ? clip_llr(im) : 0;
        add_row(6, k == 0, val, k == len - 1, ena, m, re, im, x0, x1, (fm == MOD_QPSK) ? 2 : 1);
        if (val && ena)
          odd = ~odd; // Parity moves on accepted symbols only
      end
    end
  endtask

  task automatic drive(input row_t r);
    iclkena = r.ena;
    isop    = r.sop;
    ival    = r.val;
    ieop    = r.eop;
    imod    = r.mod;
    idat_re = r.re;
    idat_im = r.im;
  endtask

  task automatic observe(input logic ena);
    row_t e;
    if (!ena) begin
      check_flags("oval/osop in stall", {oval, osop}, prev_flags); // Frozen pipeline
    end else begin
      ena_cnt++;
      if (oval && exp_q.size() == 0) begin
        errors++;
        $display("output at %0t ns with no input waiting for it", $time);
      end else if (oval) begin
        e = exp_q.pop_front();
        test_out++;
        total_out++;
        if (ena_cnt != e.acc_edge + 2) begin
          errors++;
          $display("output at %0t ns came %0d enabled cycles after its input instead of 3",
                   $time, ena_cnt - e.acc_edge + 1);
        end
        check_llr("ollr0", ollr0, e.l0);
        check_llr("ollr1", ollr1, e.l1);
        check_num("onum", onum, e.num);
        check_flags("osop/oeop", {osop, oeop}, {e.sop, e.eop});
      end
    end
    prev_flags = {oval, osop};
  endtask

  // Drive 1 ns after the edge, look at the outputs 1 ns after the next one
  task automatic apply_row(input row_t r);
    drive(r);
    if (r.ena && r.val) begin
      r.acc_edge = ena_cnt + 1;
      exp_q.push_back(r);
    end
    @(posedge iclk);
    #1;
    observe(r.ena);
  endtask

  task automatic run_test(input int t);
    int waited;
    int err0;
    err0     = errors;
    test_out = 0;
    foreach (rows[n]) begin
      if (rows[n].test == t)
        apply_row(rows[n]);
    end
    waited = 0;
    while (exp_q.size() != 0 && waited < 16) begin // Flush the pipeline
      apply_row(idle);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d outputs of test %0d never came out", exp_q.size(), t);
      timed_out = 1'b1;
    end
    $display("test %0d %s: %0d outputs, %0d errors", t, names[t], test_out, errors - err0);
  endtask

  initial begin
    int waited;
    idle     = '0;
    idle.ena = 1'b1;
    drive(idle); // Inputs defined from time 0
    load_directed();
    fill_random();
    waited = 0;
    do begin
      @(posedge iclk);
      waited++;
    end while (rst !== 1'b0 && waited < 10);
    #1;
    if (rst !== 1'b0) begin
      $display("timeout: reset was never released");
      timed_out = 1'b1;
    end else begin
      test_out = 0;
      check_flags("oval/osop after reset", {oval, osop}, 2'b00);
      check_num("onum after reset", onum, 2'd0);
      repeat (3) apply_row(idle); // Idle input stays silent
      $display("test 0 %s: %0d outputs, %0d errors", names[0], test_out, errors);
      for (int t = 1; t < 7 && !timed_out; t++)
        run_test(t);
    end
    $display("rows %0d, outputs %0d, errors %0d", rows.size(), total_out, errors);
    if (errors == 0 && !timed_out)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule : tb_dvb_soft_demapper

`default_nettype wire

//--- tb.f
+incdir+hdl
hdl/dvb_frame_pkg.sv
hdl/dvb_llr_pkg.sv
hdl/demap_mode_decode.sv
hdl/demap_metric_calc.sv
hdl/demap_llr_sat.sv
hdl/dvb_soft_demapper.sv
bench/tb_clkgen.sv
bench/tb_dvb_soft_demapper.sv

//--- run.sh
#!/bin/sh
# Build the demapper testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module tb_dvb_soft_demapper \
  -o sim_demapper > build.log 2>&1 \
  && ./obj_dir/sim_demapper > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && exit 1 || exit 0
